// File: testbench/lsu_cases.txt
# name cmd(0 load, 1 store) op(funct3) addr wdata mask rd commit_id mem_word hold
# hold 1 keeps ar_ready low while the group queues, hold 2 raises the interrupt
lb_off0 0 0 00001000 00000000 0 01 1 8091a2f3 0
lb_off1 0 0 00001001 00000000 0 02 2 8091a2f3 0
lb_off2 0 0 00001002 00000000 0 03 3 8091a2f3 0
lb_off3 0 0 00001003 00000000 0 04 4 8091a2f3 0
lbu_off1 0 4 00001005 00000000 0 05 5 7f80c311 0
lbu_off3 0 4 00001007 00000000 0 06 6 7f80c311 0
lh_off0 0 1 00001008 00000000 0 07 7 12348765 0
lh_off2 0 1 0000100a 00000000 0 08 0 8765abcd 0
lhu_off2 0 5 0000100e 00000000 0 09 1 8765abcd 0
lw_word 0 2 00001010 00000000 0 0a 2 deadbeef 0
st_word 1 0 00002000 cafef00d f 00 3 00000000 0
st_byte 1 0 00002004 000000a5 1 00 4 00000000 0
st_half 1 0 00002008 5a5a0000 c 00 5 00000000 0
hold_a 0 4 00003000 00000000 0 0b 3 01020384 1
hold_b 0 4 00003002 00000000 0 0c 4 01820304 1
hold_c 0 5 00003000 00000000 0 0d 5 0102f304 1
hold_d 0 2 00003004 00000000 0 0e 6 a5a55a5a 1
hold_e 0 0 00003003 00000000 0 0f 7 f0e0d0c0 1
irq_load 0 2 00004000 00000000 0 10 0 11111111 2

// File: tb.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_req_queue.sv
hw/lsu_load_path.sv
hw/lsu_store_path.sv
hw/lsu_top.sv
testbench/lsu_clkgen.sv
testbench/lsu_asserts.sv
testbench/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f tb.f --top-module $(TOP) -Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/lsu_tb.sv
// load/store unit testbench with memory model, case file reader and result checks
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;
    import lsu_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic                 req_mem_i;
    lsu_req_t             req_i;
    logic                 int_assert_i;
    logic                 mem_stall_o;
    logic                 mem_busy_o;
    logic                 reg_we_o;
    lsu_wb_t              wb_o;
    logic [`LSU_XLEN-1:0] ar_addr_o;
    logic                 ar_valid_o;
    logic                 ar_ready_i;
    logic [`LSU_XLEN-1:0] r_data_i;
    logic                 r_valid_i;
    logic [`LSU_XLEN-1:0] aw_addr_o;
    logic                 aw_valid_o;
    logic                 aw_ready_i;
    store_beat_t          w_beat_o;
    logic                 w_valid_o;
    logic                 w_ready_i;

    // cases from the file
    lsu_req_t    case_req[$];
    string       case_name[$];
    logic [31:0] case_word[$];
    int          case_hold[$];

    // expected results in order
    lsu_wb_t     exp_wb[$];
    string       exp_wb_name[$];
    store_beat_t exp_beat[$];
    string       exp_beat_name[$];

    // case indices waiting for their address handshake
    int          ar_idx[$];
    int          aw_idx[$];

    // memory model state
    logic [31:0] rd_data[$];
    int          rd_due[$];
    int          last_due;
    int          beats_buffered;
    logic        ar_hold;
    logic [31:0] lfsr_state = 32'd32;

    int cycle = 0;
    int limit;
    int tests_run;
    int tests_failed;
    int other_errors;

    lsu_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    lsu_top DUT (
        .clk(clk), .rst_n(rst_n), .req_mem_i(req_mem_i), .req_i(req_i),
        .int_assert_i(int_assert_i), .mem_stall_o(mem_stall_o), .mem_busy_o(mem_busy_o),
        .reg_we_o(reg_we_o), .wb_o(wb_o),
        .ar_addr_o(ar_addr_o), .ar_valid_o(ar_valid_o), .ar_ready_i(ar_ready_i),
        .r_data_i(r_data_i), .r_valid_i(r_valid_i),
        .aw_addr_o(aw_addr_o), .aw_valid_o(aw_valid_o), .aw_ready_i(aw_ready_i),
        .w_beat_o(w_beat_o), .w_valid_o(w_valid_o), .w_ready_i(w_ready_i)
    );

    // galois lfsr, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return b;
    endfunction

    // load result from the rules: pick the part, then extend it
    function automatic logic [31:0] expect_load(load_op_e op, logic [1:0] off,
                                                logic [31:0] word);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (op)
            LB:      return {{24{sh[7]}}, sh[7:0]};
            LBU:     return {24'h0, sh[7:0]};
            LH:      return {{16{sh[15]}}, sh[15:0]};
            LHU:     return {16'h0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic check_wb(string name, lsu_wb_t exp, lsu_wb_t act);
        tests_run++;
        if (act !== exp) begin
            tests_failed++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end else begin
            $display("[PASS] %s", name);
        end
    endtask

    task automatic check_beat(string name, store_beat_t exp, store_beat_t act);
        tests_run++;
        if (act !== exp) begin
            tests_failed++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end else begin
            $display("[PASS] %s", name);
        end
    endtask

    // address seen at a handshake, part of the case but not its closing result
    task automatic check_addr(string name, logic [`LSU_XLEN-1:0] exp,
                              logic [`LSU_XLEN-1:0] act);
        if (act !== exp) begin
            other_errors++;
            $display("[FAIL] %s address expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        string       nm;
        logic [31:0] v[9];
        int          hold;
        lsu_req_t    r;
        fd = $fopen("testbench/lsu_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d", nm, v[0], v[1], v[2],
                            v[3], v[4], v[5], v[6], v[7], hold);
                if (n == 10) begin
                    r.cmd       = mem_cmd_e'(v[0][0]);
                    r.op        = load_op_e'(v[1][2:0]);
                    r.addr      = v[2];
                    r.wdata     = v[3];
                    r.wmask     = v[4][3:0];
                    r.rd        = v[5][4:0];
                    r.commit_id = v[6][2:0];
                    case_req.push_back(r);
                    case_name.push_back(nm);
                    case_word.push_back(v[7]);
                    case_hold.push_back(hold);
                end
            end
        end
        $fclose(fd);
    endtask

    // one request per cycle, held while stalled
    task automatic present(int idx, bit expect_stall);
        bit          taken;
        lsu_req_t    r;
        lsu_wb_t     w;
        store_beat_t b;
        taken = 1'b0;
        r = case_req[idx];
        while (!taken) begin
            @(negedge clk);
            req_mem_i = 1'b1;
            req_i     = r;
            #1;
            if (expect_stall) begin
                if (!mem_stall_o) begin
                    $display("%s: mem_stall_o stayed low with a full queue", case_name[idx]);
                    other_errors++;
                end
                expect_stall = 1'b0;
                ar_hold = 1'b0;
            end
            if (!mem_stall_o) begin
                taken = 1'b1;
                if (r.cmd == MEM_LOAD) begin
                    w.data      = expect_load(r.op, r.addr[1:0], case_word[idx]);
                    w.rd        = r.rd;
                    w.commit_id = r.commit_id;
                    exp_wb.push_back(w);
                    exp_wb_name.push_back(case_name[idx]);
                    ar_idx.push_back(idx);
                end else begin
                    b.data = r.wdata;
                    b.strb = r.wmask;
                    exp_beat.push_back(b);
                    exp_beat_name.push_back(case_name[idx]);
                    aw_idx.push_back(idx);
                end
            end
        end
    endtask

    task automatic drain();
        @(negedge clk);
        req_mem_i = 1'b0;
        req_i     = '0;
        while (exp_wb.size() > 0 || exp_beat.size() > 0 || mem_busy_o) begin
            @(negedge clk);
        end
    endtask

    // request under interrupt must leave no trace
    task automatic run_interrupt(int idx);
        bit quiet;
        @(negedge clk);
        int_assert_i = 1'b1;
        req_mem_i    = 1'b1;
        req_i        = case_req[idx];
        #1;
        quiet = !ar_valid_o && !aw_valid_o;
        @(negedge clk);
        int_assert_i = 1'b0;
        req_mem_i    = 1'b0;
        req_i        = '0;
        repeat (8) @(negedge clk);
        tests_run++;
        if (!quiet) begin
            tests_failed++;
            $display("[FAIL] %s expected valid 0 actual ar %b aw %b", case_name[idx],
                     ar_valid_o, aw_valid_o);
        end else begin
            $display("[PASS] %s", case_name[idx]);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit != 0 && cycle >= limit) begin
            $display("run stopped by timeout after %0d cycles", cycle);
            $display("Test failed");
            $finish;
        end
    end

    // memory side inputs change on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            ar_ready_i = 1'b0;
            if (!ar_hold) begin
                ar_ready_i = lfsr_bit();
            end
            aw_ready_i = lfsr_bit();
            w_ready_i  = lfsr_bit();
            if (rd_due.size() > 0 && rd_due[0] <= cycle) begin
                r_valid_i = 1'b1;
                r_data_i  = rd_data.pop_front();
                void'(rd_due.pop_front());
            end else begin
                r_valid_i = 1'b0;
                r_data_i  = '0;
            end
        end
    end

    // sample just before the rising edge
    always @(negedge clk) begin
        int lat;
        int due;
        int k;
        #9;
        if (rst_n) begin
            if (mem_busy_o !== (beats_buffered != 0)) begin
                $display("mem_busy_o is %b with %0d beats buffered", mem_busy_o,
                         beats_buffered);
                other_errors++;
            end
            if (ar_valid_o && ar_ready_i) begin
                lat = 1 + int'({lfsr_bit(), lfsr_bit()}) % 3;
                due = cycle + lat;
                if (rd_due.size() > 0 && due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                if (ar_idx.size() == 0) begin
                    $display("read address handshake with no load requested");
                    other_errors++;
                end else begin
                    k = ar_idx.pop_front();
                    check_addr(case_name[k], case_req[k].addr, ar_addr_o);
                    rd_data.push_back(case_word[k]);
                    rd_due.push_back(due);
                end
            end
            if (aw_valid_o && aw_ready_i) begin
                if (aw_idx.size() == 0) begin
                    $display("write address handshake with no store requested");
                    other_errors++;
                end else begin
                    k = aw_idx.pop_front();
                    check_addr(case_name[k], case_req[k].addr, aw_addr_o);
                end
            end
            if (reg_we_o) begin
                if (exp_wb.size() == 0) begin
                    $display("writeback with no load outstanding");
                    other_errors++;
                end else begin
                    check_wb(exp_wb_name.pop_front(), exp_wb.pop_front(), wb_o);
                end
            end
            if (w_valid_o && w_ready_i) begin
                if (exp_beat.size() == 0) begin
                    $display("write beat with no store outstanding");
                    other_errors++;
                end else begin
                    check_beat(exp_beat_name.pop_front(), exp_beat.pop_front(), w_beat_o);
                end
            end
            beats_buffered = beats_buffered + int'(aw_valid_o && aw_ready_i)
                             - int'(w_valid_o && w_ready_i);
        end
    end

    initial begin
        int i;
        int grp;
        req_mem_i      = 1'b0;
        req_i          = '0;
        int_assert_i   = 1'b0;
        ar_ready_i     = 1'b0;
        aw_ready_i     = 1'b0;
        w_ready_i      = 1'b0;
        r_valid_i      = 1'b0;
        r_data_i       = '0;
        ar_hold        = 1'b0;
        limit          = 0;
        last_due       = 0;
        beats_buffered = 0;
        tests_run      = 0;
        tests_failed   = 0;
        other_errors   = 0;
        read_cases();
        limit = 60 * case_req.size() + 100;
        wait (rst_n);
        i = 0;
        while (i < case_req.size()) begin
            if (case_hold[i] == 2) begin
                drain();
                run_interrupt(i);
                i++;
            end else if (case_hold[i] == 1) begin
                drain();
                ar_hold = 1'b1;
                grp = 0;
                while (i < case_req.size() && case_hold[i] == 1) begin
                    present(i, grp == `LSU_QUEUE_DEPTH);
                    grp++;
                    i++;
                end
                ar_hold = 1'b0;
            end else begin
                present(i, 1'b0);
                i++;
            end
        end
        drain();
        repeat (5) @(negedge clk);
        $display("%0d tests, %0d failed, %0d other errors", tests_run, tests_failed,
                 other_errors);
        if (tests_failed == 0 && other_errors == 0 && tests_run == case_req.size()) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/lsu_asserts.sv
// protocol assertions bound to the load/store unit top level
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts (
    input logic clk,
    input logic rst_n,
    input logic reg_we_i,
    input logic r_valid_i,
    input logic ar_valid_i,
    input logic ar_ready_i,
    input logic aw_valid_i,
    input logic aw_ready_i,
    input logic w_valid_i,
    input logic w_ready_i
);
    // writeback exactly when read data arrives
    wb_needs_data: assert property (@(posedge clk) disable iff (!rst_n)
        reg_we_i == r_valid_i)
        else $error("reg_we_o and r_valid_i disagree");

    ar_held: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_i && !ar_ready_i |=> ar_valid_i)
        else $error("ar_valid_o dropped before ar_ready_i");

    aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_i && !aw_ready_i |=> aw_valid_i)
        else $error("aw_valid_o dropped before aw_ready_i");

    w_held: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_i && !w_ready_i |=> w_valid_i)
        else $error("w_valid_o dropped before w_ready_i");

    idle_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(ar_valid_i || aw_valid_i || w_valid_i || reg_we_i))
        else $error("valid output high during reset");

endmodule

bind lsu_top lsu_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_we_i   (reg_we_o),
    .r_valid_i  (r_valid_i),
    .ar_valid_i (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .aw_valid_i (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .w_valid_i  (w_valid_o),
    .w_ready_i  (w_ready_i)
);

`default_nettype wire

// File: testbench/lsu_clkgen.sv
// clock and reset generator for the load/store unit testbench, 20 ns period
`timescale 1ns/1ps
`default_nettype none

module lsu_clkgen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        // two cycles of reset, released away from the rising edge
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
// load/store unit top joining the request queue to the load and store paths
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_mem_i,
    input  lsu_pkg::lsu_req_t    req_i,
    input  logic                 int_assert_i,
    output logic                 mem_stall_o,
    output logic                 mem_busy_o,
    output logic                 reg_we_o,
    output lsu_pkg::lsu_wb_t     wb_o,
    // read address and data
    output logic [`LSU_XLEN-1:0] ar_addr_o,
    output logic                 ar_valid_o,
    input  logic                 ar_ready_i,
    input  logic [`LSU_XLEN-1:0] r_data_i,
    input  logic                 r_valid_i,
    // write address and data
    output logic [`LSU_XLEN-1:0] aw_addr_o,
    output logic                 aw_valid_o,
    input  logic                 aw_ready_i,
    output lsu_pkg::store_beat_t w_beat_o,
    output logic                 w_valid_o,
    input  logic                 w_ready_i
);
    import lsu_pkg::*;

    lsu_req_t head;
    logic     head_valid;
    logic     ar_fire;
    logic     aw_fire;

    lsu_req_queue u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_mem_i    (req_mem_i),
        .req_i        (req_i),
        .int_assert_i (int_assert_i),
        .ar_fire_i    (ar_fire),
        .aw_fire_i    (aw_fire),
        .head_o       (head),
        .head_valid_o (head_valid),
        .mem_stall_o  (mem_stall_o)
    );

    lsu_load_path u_load (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_i       (head),
        .head_valid_i (head_valid),
        .ar_ready_i   (ar_ready_i),
        .r_valid_i    (r_valid_i),
        .r_data_i     (r_data_i),
        .ar_addr_o    (ar_addr_o),
        .ar_valid_o   (ar_valid_o),
        .ar_fire_o    (ar_fire),
        .reg_we_o     (reg_we_o),
        .wb_o         (wb_o)
    );

    lsu_store_path u_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_i       (head),
        .head_valid_i (head_valid),
        .aw_ready_i   (aw_ready_i),
        .w_ready_i    (w_ready_i),
        .aw_addr_o    (aw_addr_o),
        .aw_valid_o   (aw_valid_o),
        .aw_fire_o    (aw_fire),
        .w_valid_o    (w_valid_o),
        .w_beat_o     (w_beat_o),
        .mem_busy_o   (mem_busy_o)
    );

endmodule

`default_nettype wire

// File: hw/lsu_store_path.sv
// store path issuing write addresses and buffering write beats the data channel has not taken
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_store_path (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lsu_pkg::lsu_req_t     head_i,
    input  logic                  head_valid_i,
    input  logic                  aw_ready_i,
    input  logic                  w_ready_i,
    output logic [`LSU_XLEN-1:0]  aw_addr_o,
    output logic                  aw_valid_o,
    output logic                  aw_fire_o,
    output logic                  w_valid_o,
    output lsu_pkg::store_beat_t  w_beat_o,
    output logic                  mem_busy_o
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(`LSU_WBUF_DEPTH);
    localparam int CNT_W = $clog2(`LSU_WBUF_DEPTH + 1);

    store_beat_t wbuf [`LSU_WBUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wbuf_empty;
    logic             wbuf_full;
    logic             push;
    logic             pop;
    store_beat_t      head_beat;

    assign wbuf_empty = (count == '0);
    assign wbuf_full  = (count == CNT_W'(`LSU_WBUF_DEPTH));

    assign aw_addr_o  = head_i.addr;
    assign aw_valid_o = head_valid_i && (head_i.cmd == MEM_STORE) && !wbuf_full;
    assign aw_fire_o  = aw_valid_o && aw_ready_i;

    assign head_beat = '{data: head_i.wdata, strb: head_i.wmask};

    // a beat only goes out once its address is accepted, older beats first
    assign w_valid_o = !wbuf_empty || aw_fire_o;
    assign w_beat_o  = wbuf_empty ? head_beat : wbuf[rd_ptr];

    assign pop  = !wbuf_empty && w_ready_i;
    assign push = aw_fire_o && !(wbuf_empty && w_ready_i);

    assign mem_busy_o = !wbuf_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            wbuf[wr_ptr] <= head_beat;
        end
    end

endmodule

`default_nettype wire

// File: hw/lsu_load_path.sv
// load path issuing read addresses, tracking pending loads and extracting writeback data
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_load_path (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lsu_pkg::lsu_req_t    head_i,
    input  logic                 head_valid_i,
    input  logic                 ar_ready_i,
    input  logic                 r_valid_i,
    input  logic [`LSU_XLEN-1:0] r_data_i,
    output logic [`LSU_XLEN-1:0] ar_addr_o,
    output logic                 ar_valid_o,
    output logic                 ar_fire_o,
    output logic                 reg_we_o,
    output lsu_pkg::lsu_wb_t     wb_o
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(`LSU_PEND_DEPTH);
    localparam int CNT_W = $clog2(`LSU_PEND_DEPTH + 1);

    load_tag_t pend [`LSU_PEND_DEPTH];

    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 pend_empty;
    logic                 pend_full;
    logic                 pend_pop;
    load_tag_t            new_tag;
    load_tag_t            cur_tag;
    logic [7:0]           byte_sel;
    logic [15:0]          half_sel;
    logic [`LSU_XLEN-1:0] ld_data;

    assign pend_empty = (count == '0);
    assign pend_full  = (count == CNT_W'(`LSU_PEND_DEPTH));

    // address channel, held off while every tag slot is taken
    assign ar_addr_o  = head_i.addr;
    assign ar_valid_o = head_valid_i && (head_i.cmd == MEM_LOAD) && !pend_full;
    assign ar_fire_o  = ar_valid_o && ar_ready_i;

    assign new_tag = '{
        op:        head_i.op,
        offset:    head_i.addr[1:0],
        rd:        head_i.rd,
        commit_id: head_i.commit_id
    };

    // data returns in order and never in the cycle of its own address
    assign pend_pop = r_valid_i && !pend_empty;
    assign cur_tag  = pend[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (ar_fire_o) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pend_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({ar_fire_o, pend_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire_o) begin
            pend[wr_ptr] <= new_tag;
        end
    end

    // byte lane by offset, half by the upper offset bit
    assign byte_sel = r_data_i[{cur_tag.offset, 3'b000} +: 8];
    assign half_sel = cur_tag.offset[1] ? r_data_i[31:16] : r_data_i[15:0];

    always_comb begin
        case (cur_tag.op)
            LB:      ld_data = {{(`LSU_XLEN-8){byte_sel[7]}}, byte_sel};
            LBU:     ld_data = {{(`LSU_XLEN-8){1'b0}}, byte_sel};
            LH:      ld_data = {{(`LSU_XLEN-16){half_sel[15]}}, half_sel};
            LHU:     ld_data = {{(`LSU_XLEN-16){1'b0}}, half_sel};
            default: ld_data = r_data_i;
        endcase
    end

    // writeback in the same cycle as the returning data
    assign reg_we_o = pend_pop;
    assign wb_o     = '{data: ld_data, rd: cur_tag.rd, commit_id: cur_tag.commit_id};

endmodule

`default_nettype wire

// File: hw/lsu_req_queue.sv
// request queue holding requests the memory side has not taken, with bypass when empty
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_req_queue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_mem_i,
    input  lsu_pkg::lsu_req_t req_i,
    input  logic              int_assert_i,
    input  logic              ar_fire_i,
    input  logic              aw_fire_i,
    output lsu_pkg::lsu_req_t head_o,
    output logic              head_valid_o,
    output logic              mem_stall_o
);
    import lsu_pkg::*;

    localparam int PTR_W = $clog2(`LSU_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`LSU_QUEUE_DEPTH + 1);

    lsu_req_t mem [`LSU_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             full;
    logic             live;
    logic             fire;
    logic             push;
    logic             pop;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(`LSU_QUEUE_DEPTH));

    // a new request the core wants serviced now
    assign live = req_mem_i && !int_assert_i;
    assign fire = ar_fire_i || aw_fire_i;

    // oldest entry first, live request goes straight through when empty
    assign head_o       = empty ? req_i : mem[rd_ptr];
    assign head_valid_o = (!empty || req_mem_i) && !int_assert_i;

    assign pop = !empty && fire;

    // when empty and a fire happened, the live request was the head and is gone
    assign push = live && !full && (!empty || !fire);

    // source must hold the request and present it again
    assign mem_stall_o = live && full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/lsu_pkg.sv
// load/store unit types for opcodes, requests, load tags, writeback and store beats
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_cmd_e;

    // encodings follow the RISC-V funct3 field
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_op_e;

    typedef struct packed {
        mem_cmd_e                     cmd;
        load_op_e                     op;
        logic [`LSU_REG_ADDR_W-1:0]   rd;
        logic [`LSU_XLEN-1:0]         addr;
        logic [`LSU_XLEN-1:0]         wdata;
        logic [`LSU_XLEN/8-1:0]       wmask;
        logic [`LSU_COMMIT_ID_W-1:0]  commit_id;
    } lsu_req_t;

    // what a load needs to remember until its data returns
    typedef struct packed {
        load_op_e                     op;
        logic [1:0]                   offset;
        logic [`LSU_REG_ADDR_W-1:0]   rd;
        logic [`LSU_COMMIT_ID_W-1:0]  commit_id;
    } load_tag_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]         data;
        logic [`LSU_REG_ADDR_W-1:0]   rd;
        logic [`LSU_COMMIT_ID_W-1:0]  commit_id;
    } lsu_wb_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]         data;
        logic [`LSU_XLEN/8-1:0]       strb;
    } store_beat_t;

endpackage

`default_nettype wire

// File: hw/lsu_consts.svh
// load/store unit constants for data width, register and commit id widths, and queue depths
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width, extraction logic assumes 32
`define LSU_XLEN 32

// register file address width
`define LSU_REG_ADDR_W 5

// commit id width from the issue stage
`define LSU_COMMIT_ID_W 3

// queue and buffer depths
`define LSU_QUEUE_DEPTH 4
`define LSU_PEND_DEPTH 4
`define LSU_WBUF_DEPTH 4

`endif
